// File: test/cpu_stimulus.txt
# P <instruction word, hex>  loaded at consecutive word addresses from 0
# E <expected UART byte, hex>  in order of transmission
P 000200B7
P 04100113
P 02208023
P FFB00193
P 0001A213
P 003032B3
P 00520333
P 03030313
P 02608023
P 4011D393
P 01C1D413
P 0083C4B3
P 02908023
P 00441513
P 40450533
P 02A08023
P 00000597
P 02B08023
P 87654637
P 32160613
P 00C02423
P 00A01683
P 0106D693
P 02D08023
P 00B04703
P 02E08023
P 003004A3
P 00201523
P 00802783
P 0087D793
P 02F08023
P 00520463
P 02608023
P 00521463
P 04200113
P 02208023
P 0001C463
P 02608023
P 0001F463
P 02608023
P 0001E463
P 0001D463
P 04300113
P 02208023
P 008008EF
P 02608023
P 03108023
P 01088967
P 02608023
P 03208023
P 0000006F
E 41
E 32
E F2
E EF
E 40
E FF
E 87
E FB
E 42
E 43
E B4
E C0

// File: files.f
source/riscv_pkg.sv
source/register_file.sv
source/fetch_stage.sv
source/decode_stage.sv
source/load_store_unit.sv
source/execute_stage.sv
source/riscv_core.sv
test/tb_riscv_core.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_riscv_core -o sim_tb
./obj_dir/sim_tb | tee sim.log

grep -q "^Simulation passed$" sim.log

// File: test/tb_riscv_core.sv
`timescale 1ns/1ns

module tb_riscv_core;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  i_load_en;
    riscv_pkg::imem_addr_t i_load_addr;
    riscv_pkg::word_t      i_load_data;
    logic                  i_wb_ack;
    logic                  o_wb_cyc;
    logic                  o_wb_stb;
    riscv_pkg::byte_t      o_wb_dat;

    riscv_pkg::word_t prog_words[$];
    riscv_pkg::byte_t exp_bytes[$];
    integer           seed = 32'h1ee4a8d7;
    int               rx_count = 0;
    int               ack_wait = 0;
    logic             busy = 1'b0;
    logic             running = 1'b0;
    riscv_pkg::byte_t held_dat;

    riscv_core i_riscv_core (
        .clk         (clk),
        .reset       (reset),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .i_wb_ack    (i_wb_ack),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_dat    (o_wb_dat)
    );

    always #2 clk = ~clk;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic read_stimulus();
        int    fd;
        int    n;
        string line;
        byte   tag;
        logic [31:0] value;
        fd = $fopen("test/cpu_stimulus.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open test/cpu_stimulus.txt");
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && $sscanf(line, "%c %h", tag, value) == 2) begin
                if (tag == "P") begin
                    prog_words.push_back(value);
                end else if (tag == "E") begin
                    exp_bytes.push_back(value[7:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    // wishbone slave with a random ack delay per byte
    always @(negedge clk) begin
        i_wb_ack = 1'b0; // ack is a single cycle pulse
        if (reset) begin
            busy = 1'b0;
            assert (!o_wb_cyc && !o_wb_stb)
                else stop_with_failure("wishbone cycle started during reset");
        end else begin
            assert (o_wb_cyc == o_wb_stb)
                else stop_with_failure("cyc and stb disagree");
            if (o_wb_stb && !busy) begin
                busy = 1'b1;
                ack_wait = $unsigned($random(seed)) % 8;
                held_dat = o_wb_dat;
            end else if (busy) begin
                assert (o_wb_stb)
                    else stop_with_failure("stb dropped before ack");
                assert (o_wb_dat == held_dat)
                    else stop_with_failure($sformatf(
                        "FAILED wb_dat_hold: expected %02h, actual %02h", held_dat, o_wb_dat));
            end
            if (busy) begin
                if (ack_wait == 0) begin
                    assert (rx_count < exp_bytes.size())
                        else stop_with_failure("more UART bytes than expected");
                    assert (o_wb_dat == exp_bytes[rx_count])
                        else stop_with_failure($sformatf(
                            "FAILED uart_byte[%0d]: expected %02h, actual %02h",
                            rx_count, exp_bytes[rx_count], o_wb_dat));
                    rx_count++;
                    i_wb_ack = 1'b1;
                    busy = 1'b0;
                end else begin
                    ack_wait--;
                end
            end
        end
    end

    // watchdog scaled by program and byte count
    initial begin
        wait (running);
        repeat (prog_words.size() * 4 + exp_bytes.size() * 12) @(posedge clk);
        stop_with_failure("timeout waiting for UART bytes");
    end

    initial begin
        reset = 1'b1;
        i_load_en = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        i_wb_ack = 1'b0;
        read_stimulus();
        // reset covers the program load and 8 more cycles
        for (int i = 0; i < prog_words.size(); i++) begin
            @(negedge clk);
            i_load_en = 1'b1;
            i_load_addr = riscv_pkg::imem_addr_t'(i);
            i_load_data = prog_words[i];
        end
        @(negedge clk);
        i_load_en = 1'b0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        running = 1'b1;
        wait (rx_count == exp_bytes.size());
        repeat (50) begin
            @(negedge clk);
            assert (!o_wb_stb)
                else stop_with_failure("UART store after the last expected byte");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: source/riscv_core.sv
`timescale 1ns/1ns

module riscv_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_load_en,
    input  riscv_pkg::imem_addr_t i_load_addr,
    input  riscv_pkg::word_t      i_load_data,
    input  logic                  i_wb_ack,
    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output riscv_pkg::byte_t      o_wb_dat
);

    riscv_pkg::word_t     fd_inst;
    riscv_pkg::word_t     fd_pc;
    riscv_pkg::op_t       de_op;
    riscv_pkg::word_t     de_a;
    riscv_pkg::word_t     de_b;
    riscv_pkg::word_t     de_imm;
    riscv_pkg::word_t     de_pc;
    riscv_pkg::reg_addr_t de_rd;
    logic                 jump;
    riscv_pkg::word_t     jump_addr;
    logic                 stall;
    logic                 wr_en;
    riscv_pkg::reg_addr_t wr_addr;
    riscv_pkg::word_t     wr_data;

    fetch_stage u_fetch (
        .clk         (clk),
        .reset       (reset),
        .i_jump      (jump),
        .i_jump_addr (jump_addr),
        .i_stall     (stall),
        .i_load_en   (i_load_en),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_inst      (fd_inst),
        .o_pc        (fd_pc)
    );

    decode_stage u_decode (
        .clk       (clk),
        .reset     (reset),
        .i_inst    (fd_inst),
        .i_pc      (fd_pc),
        .i_jump    (jump),
        .i_stall   (stall),
        .i_wr_en   (wr_en),     // write-back doubles as forwarding path
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_op      (de_op),
        .o_a       (de_a),
        .o_b       (de_b),
        .o_imm     (de_imm),
        .o_pc      (de_pc),
        .o_rd      (de_rd)
    );

    execute_stage u_execute (
        .clk         (clk),
        .reset       (reset),
        .i_op        (de_op),
        .i_a         (de_a),
        .i_b         (de_b),
        .i_imm       (de_imm),
        .i_pc        (de_pc),
        .i_rd        (de_rd),
        .i_wb_ack    (i_wb_ack),
        .o_jump      (jump),
        .o_jump_addr (jump_addr),
        .o_stall     (stall),
        .o_wr_en     (wr_en),
        .o_wr_addr   (wr_addr),
        .o_wr_data   (wr_data),
        .o_wb_cyc    (o_wb_cyc),
        .o_wb_stb    (o_wb_stb),
        .o_wb_dat    (o_wb_dat)
    );

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ns

module execute_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::op_t       i_op,
    input  riscv_pkg::word_t     i_a,
    input  riscv_pkg::word_t     i_b,
    input  riscv_pkg::word_t     i_imm,
    input  riscv_pkg::word_t     i_pc,
    input  riscv_pkg::reg_addr_t i_rd,
    input  logic                 i_wb_ack,
    output logic                 o_jump,
    output riscv_pkg::word_t     o_jump_addr,
    output logic                 o_stall,
    output logic                 o_wr_en,
    output riscv_pkg::reg_addr_t o_wr_addr,
    output riscv_pkg::word_t     o_wr_data,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output riscv_pkg::byte_t     o_wb_dat
);

    riscv_pkg::word_t load_data;
    riscv_pkg::word_t pc_plus4;
    logic             writes;

    load_store_unit u_lsu (
        .clk          (clk),
        .reset        (reset),
        .i_op         (i_op),
        .i_base       (i_a),
        .i_offset     (i_imm),
        .i_store_data (i_b),
        .i_wb_ack     (i_wb_ack),
        .o_load_data  (load_data),
        .o_stall      (o_stall),
        .o_wb_cyc     (o_wb_cyc),
        .o_wb_stb     (o_wb_stb),
        .o_wb_dat     (o_wb_dat)
    );

    assign pc_plus4 = i_pc + 32'd4; // link value

    always_comb begin
        o_wr_data = '0;
        o_jump = 1'b0;
        o_jump_addr = i_pc + i_imm; // branch and jal target
        case (i_op)
            riscv_pkg::OP_LUI: o_wr_data = i_imm;
            riscv_pkg::OP_AUIPC: o_wr_data = i_pc + i_imm;
            riscv_pkg::OP_JAL: begin
                o_wr_data = pc_plus4;
                o_jump = 1'b1;
            end
            riscv_pkg::OP_JALR: begin
                o_wr_data = pc_plus4;
                o_jump = 1'b1;
                o_jump_addr = (i_a + i_imm) & ~32'd1;
            end
            riscv_pkg::OP_BEQ: o_jump = (i_a == i_b);
            riscv_pkg::OP_BNE: o_jump = (i_a != i_b);
            riscv_pkg::OP_BLT: o_jump = ($signed(i_a) < $signed(i_b));
            riscv_pkg::OP_BGE: o_jump = ($signed(i_a) >= $signed(i_b));
            riscv_pkg::OP_BLTU: o_jump = (i_a < i_b);
            riscv_pkg::OP_BGEU: o_jump = (i_a >= i_b);
            riscv_pkg::OP_LB, riscv_pkg::OP_LH, riscv_pkg::OP_LW,
            riscv_pkg::OP_LBU, riscv_pkg::OP_LHU: o_wr_data = load_data;
            riscv_pkg::OP_ADDI: o_wr_data = i_a + i_imm;
            riscv_pkg::OP_SLTI: o_wr_data = {31'b0, $signed(i_a) < $signed(i_imm)};
            riscv_pkg::OP_SLTIU: o_wr_data = {31'b0, i_a < i_imm};
            riscv_pkg::OP_XORI: o_wr_data = i_a ^ i_imm;
            riscv_pkg::OP_ORI: o_wr_data = i_a | i_imm;
            riscv_pkg::OP_ANDI: o_wr_data = i_a & i_imm;
            riscv_pkg::OP_SLLI: o_wr_data = i_a << i_imm[4:0];
            riscv_pkg::OP_SRLI: o_wr_data = i_a >> i_imm[4:0];
            riscv_pkg::OP_SRAI: o_wr_data = $signed(i_a) >>> i_imm[4:0];
            riscv_pkg::OP_ADD: o_wr_data = i_a + i_b;
            riscv_pkg::OP_SUB: o_wr_data = i_a - i_b;
            riscv_pkg::OP_SLL: o_wr_data = i_a << i_b[4:0];
            riscv_pkg::OP_SLT: o_wr_data = {31'b0, $signed(i_a) < $signed(i_b)};
            riscv_pkg::OP_SLTU: o_wr_data = {31'b0, i_a < i_b};
            riscv_pkg::OP_XOR: o_wr_data = i_a ^ i_b;
            riscv_pkg::OP_SRL: o_wr_data = i_a >> i_b[4:0];
            riscv_pkg::OP_SRA: o_wr_data = $signed(i_a) >>> i_b[4:0];
            riscv_pkg::OP_OR: o_wr_data = i_a | i_b;
            riscv_pkg::OP_AND: o_wr_data = i_a & i_b;
            default: ;
        endcase
    end

    always_comb begin
        case (i_op)
            riscv_pkg::OP_NOP, riscv_pkg::OP_SB, riscv_pkg::OP_SH, riscv_pkg::OP_SW,
            riscv_pkg::OP_BEQ, riscv_pkg::OP_BNE, riscv_pkg::OP_BLT,
            riscv_pkg::OP_BGE, riscv_pkg::OP_BLTU, riscv_pkg::OP_BGEU: writes = 1'b0;
            default: writes = 1'b1;
        endcase
    end

    assign o_wr_en = writes && (i_rd != '0); // x0 stays zero
    assign o_wr_addr = i_rd;

endmodule

// File: source/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  logic             clk,
    input  logic             reset,
    input  riscv_pkg::op_t   i_op,
    input  riscv_pkg::word_t i_base,
    input  riscv_pkg::word_t i_offset,
    input  riscv_pkg::word_t i_store_data,
    input  logic             i_wb_ack,
    output riscv_pkg::word_t o_load_data,
    output logic             o_stall,
    output logic             o_wb_cyc,
    output logic             o_wb_stb,
    output riscv_pkg::byte_t o_wb_dat
);

    riscv_pkg::word_t                        dmem [riscv_pkg::DMEM_WORDS];
    logic [$clog2(riscv_pkg::DMEM_WORDS)-1:0] dmem_idx;
    riscv_pkg::word_t                        addr;
    riscv_pkg::word_t                        rd_word;
    riscv_pkg::word_t                        wr_word;
    riscv_pkg::byte_t                        ld_byte;
    logic [15:0]                             ld_half;
    logic [3:0]                              byte_en;
    logic                                    uart_req;

    assign addr = i_base + i_offset;
    assign dmem_idx = addr[2 +: $clog2(riscv_pkg::DMEM_WORDS)]; // aliases modulo size
    assign rd_word = dmem[dmem_idx];
    assign uart_req = (i_op == riscv_pkg::OP_SB) && (addr == riscv_pkg::UART_TX_ADDR);

    // data replicated to every lane so the enables pick the lane
    always_comb begin
        byte_en = 4'b0000;
        wr_word = i_store_data;
        case (i_op)
            riscv_pkg::OP_SB: begin
                byte_en = uart_req ? 4'b0000 : 4'b0001 << addr[1:0];
                wr_word = {4{i_store_data[7:0]}};
            end
            riscv_pkg::OP_SH: begin
                byte_en = addr[1] ? 4'b1100 : 4'b0011;
                wr_word = {2{i_store_data[15:0]}};
            end
            riscv_pkg::OP_SW: byte_en = 4'b1111;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
                dmem[dmem_idx][8*i +: 8] <= wr_word[8*i +: 8];
            end
        end
    end

    assign ld_byte = rd_word[{addr[1:0], 3'b000} +: 8];
    assign ld_half = addr[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (i_op)
            riscv_pkg::OP_LB: o_load_data = {{24{ld_byte[7]}}, ld_byte};
            riscv_pkg::OP_LBU: o_load_data = {24'b0, ld_byte};
            riscv_pkg::OP_LH: o_load_data = {{16{ld_half[15]}}, ld_half};
            riscv_pkg::OP_LHU: o_load_data = {16'b0, ld_half};
            default: o_load_data = rd_word;
        endcase
    end

    // uart byte goes out as one classic write held until ack
    assign o_wb_cyc = uart_req;
    assign o_wb_stb = uart_req;
    assign o_wb_dat = i_store_data[7:0];
    assign o_stall = uart_req && !i_wb_ack;

    // the held decode/execute register must keep the byte steady
    a_wb_dat_stable: assert property (@(posedge clk) disable iff (reset)
        o_wb_stb && !i_wb_ack |=> $stable(o_wb_dat));

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns

module decode_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  riscv_pkg::word_t     i_inst,
    input  riscv_pkg::word_t     i_pc,
    input  logic                 i_jump,
    input  logic                 i_stall,
    input  logic                 i_wr_en,
    input  riscv_pkg::reg_addr_t i_wr_addr,
    input  riscv_pkg::word_t     i_wr_data,
    output riscv_pkg::op_t       o_op,
    output riscv_pkg::word_t     o_a,
    output riscv_pkg::word_t     o_b,
    output riscv_pkg::word_t     o_imm,
    output riscv_pkg::word_t     o_pc,
    output riscv_pkg::reg_addr_t o_rd
);

    logic [6:0]           opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    riscv_pkg::reg_addr_t rs1;
    riscv_pkg::reg_addr_t rs2;
    riscv_pkg::word_t     rs1_data;
    riscv_pkg::word_t     rs2_data;
    riscv_pkg::word_t     fwd_a;
    riscv_pkg::word_t     fwd_b;
    riscv_pkg::word_t     imm;
    riscv_pkg::op_t       op;

    assign opcode = i_inst[6:0];
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign rs1 = i_inst[19:15];
    assign rs2 = i_inst[24:20];

    register_file u_regs (
        .clk        (clk),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .i_wr_en    (i_wr_en),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    // execute result overrides a stale read
    assign fwd_a = (i_wr_en && i_wr_addr == rs1) ? i_wr_data : rs1_data;
    assign fwd_b = (i_wr_en && i_wr_addr == rs2) ? i_wr_data : rs2_data;

    always_comb begin
        case (opcode)
            riscv_pkg::OPC_OPIMM, riscv_pkg::OPC_LOAD, riscv_pkg::OPC_JALR:
                imm = {{20{i_inst[31]}}, i_inst[31:20]}; // shamt in imm[4:0]
            riscv_pkg::OPC_STORE:
                imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            riscv_pkg::OPC_BRANCH:
                imm = {{20{i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
            riscv_pkg::OPC_LUI, riscv_pkg::OPC_AUIPC:
                imm = {i_inst[31:12], 12'h000};
            riscv_pkg::OPC_JAL:
                imm = {{12{i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
            default:
                imm = '0;
        endcase
    end

    always_comb begin
        op = riscv_pkg::OP_NOP; // unknown words fall through as nop
        case (opcode)
            riscv_pkg::OPC_LUI: op = riscv_pkg::OP_LUI;
            riscv_pkg::OPC_AUIPC: op = riscv_pkg::OP_AUIPC;
            riscv_pkg::OPC_JAL: op = riscv_pkg::OP_JAL;
            riscv_pkg::OPC_JALR: if (funct3 == 3'b000) op = riscv_pkg::OP_JALR;
            riscv_pkg::OPC_BRANCH: begin
                case (funct3)
                    3'b000: op = riscv_pkg::OP_BEQ;
                    3'b001: op = riscv_pkg::OP_BNE;
                    3'b100: op = riscv_pkg::OP_BLT;
                    3'b101: op = riscv_pkg::OP_BGE;
                    3'b110: op = riscv_pkg::OP_BLTU;
                    3'b111: op = riscv_pkg::OP_BGEU;
                    default: ;
                endcase
            end
            riscv_pkg::OPC_LOAD: begin
                case (funct3)
                    3'b000: op = riscv_pkg::OP_LB;
                    3'b001: op = riscv_pkg::OP_LH;
                    3'b010: op = riscv_pkg::OP_LW;
                    3'b100: op = riscv_pkg::OP_LBU;
                    3'b101: op = riscv_pkg::OP_LHU;
                    default: ;
                endcase
            end
            riscv_pkg::OPC_STORE: begin
                case (funct3)
                    3'b000: op = riscv_pkg::OP_SB;
                    3'b001: op = riscv_pkg::OP_SH;
                    3'b010: op = riscv_pkg::OP_SW;
                    default: ;
                endcase
            end
            riscv_pkg::OPC_OPIMM: begin
                case (funct3)
                    3'b000: op = riscv_pkg::OP_ADDI;
                    3'b010: op = riscv_pkg::OP_SLTI;
                    3'b011: op = riscv_pkg::OP_SLTIU;
                    3'b100: op = riscv_pkg::OP_XORI;
                    3'b110: op = riscv_pkg::OP_ORI;
                    3'b111: op = riscv_pkg::OP_ANDI;
                    3'b001: if (funct7 == 7'b0000000) op = riscv_pkg::OP_SLLI;
                    default: begin
                        if (funct7 == 7'b0000000) op = riscv_pkg::OP_SRLI;
                        else if (funct7 == 7'b0100000) op = riscv_pkg::OP_SRAI;
                    end
                endcase
            end
            riscv_pkg::OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    case (funct3)
                        3'b000: op = riscv_pkg::OP_ADD;
                        3'b001: op = riscv_pkg::OP_SLL;
                        3'b010: op = riscv_pkg::OP_SLT;
                        3'b011: op = riscv_pkg::OP_SLTU;
                        3'b100: op = riscv_pkg::OP_XOR;
                        3'b101: op = riscv_pkg::OP_SRL;
                        3'b110: op = riscv_pkg::OP_OR;
                        default: op = riscv_pkg::OP_AND;
                    endcase
                end else if (funct7 == 7'b0100000) begin
                    if (funct3 == 3'b000) op = riscv_pkg::OP_SUB;
                    else if (funct3 == 3'b101) op = riscv_pkg::OP_SRA;
                end
            end
            default: ;
        endcase
    end

    // decode/execute register
    always_ff @(posedge clk) begin
        if (reset || i_jump) begin
            o_op <= riscv_pkg::OP_NOP;
        end else if (!i_stall) begin
            o_op <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_a <= fwd_a;
            o_b <= fwd_b;
            o_imm <= imm;
            o_pc <= i_pc;
            o_rd <= i_inst[11:7];
        end
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  i_jump,
    input  riscv_pkg::word_t      i_jump_addr,
    input  logic                  i_stall,
    input  logic                  i_load_en,
    input  riscv_pkg::imem_addr_t i_load_addr,
    input  riscv_pkg::word_t      i_load_data,
    output riscv_pkg::word_t      o_inst,
    output riscv_pkg::word_t      o_pc
);

    riscv_pkg::word_t      imem [riscv_pkg::IMEM_WORDS];
    riscv_pkg::word_t      pc;
    riscv_pkg::imem_addr_t rd_idx;

    assign rd_idx = pc[$bits(riscv_pkg::imem_addr_t)+1:2]; // word index that wraps

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= riscv_pkg::RESET_PC;
        end else if (i_jump) begin
            pc <= i_jump_addr;
        end else if (!i_stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load_en) begin
            imem[i_load_addr] <= i_load_data; // program load
        end
    end

    // fetch/decode register doubles as the memory read port
    always_ff @(posedge clk) begin
        if (reset || i_jump) begin
            o_inst <= riscv_pkg::NOP_INST; // flush wrong path
        end else if (!i_stall) begin
            o_inst <= imem[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_pc <= pc;
        end
    end

    // a load while running would corrupt words already in flight
    a_load_in_reset: assert property (@(posedge clk) i_load_en |-> reset);

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic                 clk,
    input  riscv_pkg::reg_addr_t i_rs1,
    input  riscv_pkg::reg_addr_t i_rs2,
    input  logic                 i_wr_en,
    input  riscv_pkg::reg_addr_t i_wr_addr,
    input  riscv_pkg::word_t     i_wr_data,
    output riscv_pkg::word_t     o_rs1_data,
    output riscv_pkg::word_t     o_rs2_data
);

    riscv_pkg::word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

    // execute filters rd == 0 before the write reaches here
    a_no_x0_write: assert property (@(posedge clk) i_wr_en |-> i_wr_addr != '0);

endmodule

// File: source/riscv_pkg.sv
package riscv_pkg;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [7:0] byte_t;
    typedef logic [$clog2(IMEM_WORDS)-1:0] imem_addr_t;

    localparam word_t UART_TX_ADDR = 32'h0002_0020;
    localparam word_t RESET_PC = 32'h0000_0000;
    localparam word_t NOP_INST = 32'h0000_0013; // addi x0, x0, 0

    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_OP = 7'b0110011;

    // one value per supported instruction
    typedef enum logic [5:0] {
        OP_NOP,
        OP_LUI, OP_AUIPC,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } op_t;

endpackage
